/* build.f */
logic/soc_event_pkg.sv
logic/periph_evt_if.sv
logic/gpio_event_unit.sv
logic/ref_timer_unit.sv
logic/fc_event_router.sv
logic/soc_event_top.sv
dv/event_checker.sv
dv/tb_soc_event_top.sv

/* dv/event_cases.txt */
reset_idle IDLE 14 23 0
reset_idle_gpio IDLE 14 18 0
gpio_cfg_rise CFG_GPIO 00080008 18 0
gpio_rise_toggle GPIO_TOGGLE 5 18 3
gpio_cfg_off CFG_GPIO 00000000 18 0
gpio_off_toggle GPIO_TOGGLE 3 18 0
gpio_cfg_fall CFG_GPIO 00080000 18 0
gpio_fall_toggle GPIO_TOGGLE 4 18 2
ref_edges SLOW_PERIODS 3 23 6
cmp_cfg_3 CFG_CMP 00000003 16 0
cmp_periods_lo SLOW_PERIODS 7 16 2
cmp_cfg_3_again CFG_CMP 00000003 7 0
cmp_periods_mtime SLOW_PERIODS 6 7 2
stop_periods STOP_PERIODS 5 16 0
stop_ref_edges STOP_PERIODS 2 23 4
wrap_cfg CFG_CMP 00000000 17 0
wrap_periods SLOW_PERIODS 100 17 1
mask_cfg_gpio_off CFG_MASK fffbffff 18 0
mask_gpio_cfg CFG_GPIO 00080008 18 0
mask_gpio_toggle GPIO_TOGGLE 4 18 0
mask_cfg_all CFG_MASK ffffffff 18 0
mask_gpio_restored GPIO_TOGGLE 2 18 1
hwpe_pulses HWPE 5 30 5
hwpe_other_quiet HWPE 3 31 0

/* dv/event_checker.sv */
// fc event pulse checker
`timescale 1ns/1ns

module event_checker #(
  parameter int NAME_W = 8*24
) (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  // dut output under watch
  input  logic [soc_event_pkg::FC_EVT_WIDTH-1:0]         fc_events_i,
  // test window from the stimulus side
  input  logic                                          win_i,
  input  logic [NAME_W-1:0]                             name_i,
  input  logic [$clog2(soc_event_pkg::FC_EVT_WIDTH)-1:0] bit_i,
  input  int                                            exp_i,
  // running totals
  output int                                            pass_cnt_o,
  output int                                            fail_cnt_o,
  output int                                            err_cnt_o
);

  logic [soc_event_pkg::FC_EVT_WIDTH-1:0] prev_evt;
  logic                                   win_q;
  logic                                   rst_q;
  int                                     cnt;

  ////////////////////////////////////////////////////////////////////////////
  // sample on the rising edge, before the dut flops update
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      prev_evt   = '0;
      win_q      = 1'b0;
      rst_q      = 1'b0;
      cnt        = 0;
      pass_cnt_o = 0;
      fail_cnt_o = 0;
      err_cnt_o  = 0;
    end else begin
      // first cycle out of reset
      if (!rst_q && fc_events_i != '0) begin
        $display("fc event word not zero after reset, got %h", fc_events_i);
        err_cnt_o = err_cnt_o + 1;
      end
      if ((fc_events_i & ~soc_event_pkg::FC_USED_MASK) != '0) begin
        $display("reserved fc event bits set, word %h", fc_events_i);
        err_cnt_o = err_cnt_o + 1;
      end
      // window opens
      if (win_i && !win_q) begin
        cnt = 0;
      end
      // count rising pulses only
      if (win_i && fc_events_i[bit_i] && !prev_evt[bit_i]) begin
        cnt = cnt + 1;
      end
      // window closed, judge the test
      if (!win_i && win_q) begin
        if (cnt == exp_i) begin
          $display("[PASS] %0s: %0d pulses on bit %0d", name_i, cnt, bit_i);
          pass_cnt_o = pass_cnt_o + 1;
        end else begin
          $display("[FAIL] %0s: bit %0d expected %0d, actual %0d",
                   name_i, bit_i, exp_i, cnt);
          fail_cnt_o = fail_cnt_o + 1;
        end
      end
      win_q    = win_i;
      prev_evt = fc_events_i;
      rst_q    = 1'b1;
    end
  end

endmodule

/* dv/tb_soc_event_top.sv */
// soc event testbench
`timescale 1ns/1ns

module tb_soc_event_top;

  localparam int TIMER_WIDTH = 8;
  localparam int MAX_CASES   = 64;
  // cycles after the stimulus before the window closes
  localparam int SETTLE      = 10;
  localparam int MAX_GAP     = 11;
  localparam int GPIO_PIN    = 3;
  localparam int NAME_W      = 8*24;
  localparam int OP_W        = 8*16;
  localparam int BIT_W       = $clog2(soc_event_pkg::FC_EVT_WIDTH);

  // operation names as read from the case file
  localparam logic [OP_W-1:0] OP_IDLE        = "IDLE";
  localparam logic [OP_W-1:0] OP_CFG_GPIO    = "CFG_GPIO";
  localparam logic [OP_W-1:0] OP_CFG_CMP     = "CFG_CMP";
  localparam logic [OP_W-1:0] OP_CFG_MASK    = "CFG_MASK";
  localparam logic [OP_W-1:0] OP_GPIO_TOGGLE = "GPIO_TOGGLE";
  localparam logic [OP_W-1:0] OP_SLOW        = "SLOW_PERIODS";
  localparam logic [OP_W-1:0] OP_STOP        = "STOP_PERIODS";
  localparam logic [OP_W-1:0] OP_HWPE        = "HWPE";

  logic                                        clk = 1'b0;
  logic                                        rst_n;
  logic                                        cfg_we;
  logic [soc_event_pkg::CFG_ADDR_WIDTH-1:0]    cfg_addr;
  logic [31:0]                                 cfg_wdata;
  logic [soc_event_pkg::N_GPIO-1:0]            gpio_in;
  logic                                        slow_clk;
  logic                                        stoptimer;
  logic [1:0]                                  hwpe_evt;
  logic [soc_event_pkg::FC_EVT_WIDTH-1:0]      fc_events;

  // window handed to the checker
  logic                                        test_win;
  logic [NAME_W-1:0]                           test_name;
  logic [BIT_W-1:0]                            test_bit;
  int                                          test_exp;
  int                                          pass_cnt;
  int                                          fail_cnt;
  int                                          err_cnt;

  // case table
  logic [NAME_W-1:0]                           case_name [MAX_CASES];
  logic [OP_W-1:0]                             case_op   [MAX_CASES];
  logic [31:0]                                 case_arg  [MAX_CASES];
  int                                          case_bit  [MAX_CASES];
  int                                          case_exp  [MAX_CASES];
  int                                          num_cases;

  int                                          seed;
  int                                          tb_errors;
  int                                          limit_cycles = 0;
  int                                          total_cycles;
  int                                          bad;
  int                                          idx;

  always #5 clk = ~clk;

  soc_event_top #(
    .TIMER_WIDTH (TIMER_WIDTH)
  ) soc_event_top_inst (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .cfg_we_i         (cfg_we),
    .cfg_addr_i       (cfg_addr),
    .cfg_wdata_i      (cfg_wdata),
    .gpio_in_i        (gpio_in),
    .slow_clk_i       (slow_clk),
    .stoptimer_i      (stoptimer),
    .fc_hwpe_events_i (hwpe_evt),
    .fc_events_o      (fc_events)
  );

  event_checker #(
    .NAME_W (NAME_W)
  ) event_checker_inst (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .fc_events_i (fc_events),
    .win_i       (test_win),
    .name_i      (test_name),
    .bit_i       (test_bit),
    .exp_i       (test_exp),
    .pass_cnt_o  (pass_cnt),
    .fail_cnt_o  (fail_cnt),
    .err_cnt_o   (err_cnt)
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // lands 1 ns after the n-th rising edge
  task automatic next_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic write_cfg(input logic [soc_event_pkg::CFG_ADDR_WIDTH-1:0] addr,
                           input logic [31:0] data);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    next_cycles(1);
    cfg_we    = 1'b0;
  endtask

  task automatic toggle_gpio(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      gpio_in[GPIO_PIN] = ~gpio_in[GPIO_PIN];
      next_cycles(6);
    end
  endtask

  // 8 cycle periods, high half first
  task automatic run_slow_periods(input int n, input logic stop);
    int i;
    stoptimer = stop;
    for (i = 0; i < n; i++) begin
      slow_clk = 1'b1;
      next_cycles(4);
      slow_clk = 1'b0;
      next_cycles(4);
    end
    stoptimer = 1'b0;
  endtask

  task automatic pulse_hwpe(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      hwpe_evt[0] = 1'b1;
      next_cycles(1);
      hwpe_evt[0] = 1'b0;
      next_cycles(3);
    end
  endtask

  function automatic int stim_cycles(input logic [OP_W-1:0] op, input logic [31:0] arg);
    int n;
    n = int'(arg);
    if (op == OP_GPIO_TOGGLE) return 6 * n;
    if (op == OP_SLOW || op == OP_STOP) return 8 * n;
    if (op == OP_HWPE) return 4 * n;
    if (op == OP_IDLE) return n;
    return 1;
  endfunction

  task automatic apply_op(input logic [OP_W-1:0] op, input logic [31:0] arg);
    if (op == OP_CFG_GPIO) write_cfg(soc_event_pkg::CFG_GPIO_IRQ, arg);
    else if (op == OP_CFG_CMP) write_cfg(soc_event_pkg::CFG_TIMER_CMP, arg);
    else if (op == OP_CFG_MASK) write_cfg(soc_event_pkg::CFG_EVT_MASK, arg);
    else if (op == OP_GPIO_TOGGLE) toggle_gpio(int'(arg));
    else if (op == OP_SLOW) run_slow_periods(int'(arg), 1'b0);
    else if (op == OP_STOP) run_slow_periods(int'(arg), 1'b1);
    else if (op == OP_HWPE) pulse_hwpe(int'(arg));
    else if (op == OP_IDLE) next_cycles(int'(arg));
    else begin
      $display("unknown operation %0s in case file", op);
      tb_errors = tb_errors + 1;
    end
  endtask

  task automatic load_cases();
    int fd;
    int n;
    logic [NAME_W-1:0] nm;
    logic [OP_W-1:0]   op;
    logic [31:0]       arg;
    int                bt;
    int                ex;
    num_cases = 0;
    fd = $fopen("dv/event_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open case file dv/event_cases.txt");
      tb_errors = tb_errors + 1;
    end else begin
      n = $fscanf(fd, "%s %s %h %d %d\n", nm, op, arg, bt, ex);
      while (n == 5 && num_cases < MAX_CASES) begin
        case_name[num_cases] = nm;
        case_op[num_cases]   = op;
        case_arg[num_cases]  = arg;
        case_bit[num_cases]  = bt;
        case_exp[num_cases]  = ex;
        num_cases = num_cases + 1;
        n = $fscanf(fd, "%s %s %h %d %d\n", nm, op, arg, bt, ex);
      end
      // anything left over is a bad line or too many cases
      if (n > 0) begin
        $display("case file has an unreadable or extra line after case %0d", num_cases);
        tb_errors = tb_errors + 1;
      end
      $fclose(fd);
    end
  endtask

  task automatic run_case(input int i);
    int gap;
    test_name = case_name[i];
    test_bit  = BIT_W'(case_bit[i]);
    test_exp  = case_exp[i];
    test_win  = 1'b1;
    apply_op(case_op[i], case_arg[i]);
    next_cycles(SETTLE);
    test_win  = 1'b0;
    // idle gap of 4 to 11 cycles
    gap = 4 + int'($unsigned($random(seed)) % 32'd8);
    next_cycles(gap);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n     = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    gpio_in   = '0;
    slow_clk  = 1'b0;
    stoptimer = 1'b0;
    hwpe_evt  = '0;
    test_win  = 1'b0;
    test_name = '0;
    test_bit  = '0;
    test_exp  = 0;
    seed      = 32'h8a2c;
    tb_errors = 0;
    load_cases();
    total_cycles = 0;
    for (idx = 0; idx < num_cases; idx++) begin
      total_cycles = total_cycles + stim_cycles(case_op[idx], case_arg[idx]) + SETTLE + MAX_GAP;
    end
    limit_cycles = 2 * total_cycles + 1000;
    next_cycles(8);
    rst_n = 1'b1;
    next_cycles(2);
    for (idx = 0; idx < num_cases; idx++) begin
      run_case(idx);
    end
    // let the last verdict come out
    next_cycles(4);
    bad = fail_cnt + err_cnt + tb_errors;
    $display("summary: %0d tests, %0d passed, %0d failed, %0d other errors",
             num_cases, pass_cnt, fail_cnt, err_cnt + tb_errors);
    if (bad == 0 && num_cases > 0 && pass_cnt == num_cases) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog sized from the case table
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout, tests did not finish within %0d cycles", limit_cycles);
    $display("Something failed");
    $finish;
  end

endmodule

/* logic/fc_event_router.sv */
// fabric controller event router
`timescale 1ns/1ns

module fc_event_router (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  // config strobe
  input  logic                                     cfg_we_i,
  input  logic [soc_event_pkg::CFG_ADDR_WIDTH-1:0] cfg_addr_i,
  input  soc_event_pkg::cfg_word_u                 cfg_wdata_i,
  // hwpe events come in as plain pulses
  input  logic [1:0]                               fc_hwpe_events_i,
  periph_evt_if.router_mp                          evt_i,
  output logic [soc_event_pkg::FC_EVT_WIDTH-1:0]   fc_events_o
);

  logic [soc_event_pkg::FC_EVT_WIDTH-1:0] mask_q;
  logic [soc_event_pkg::FC_EVT_WIDTH-1:0] evt_word;
  logic                                   cfg_hit;

  ////////////////////////////////////////////////////////////////////////////
  // bit placement
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // reserved positions stay low
    evt_word = '0;
    // timer low on both mtime and timer lines
    evt_word[soc_event_pkg::FC_BIT_TIMER_LO_M] = evt_i.timer_lo;
    evt_word[soc_event_pkg::FC_BIT_TIMER_LO]   = evt_i.timer_lo;
    evt_word[soc_event_pkg::FC_BIT_TIMER_HI]   = evt_i.timer_hi;
    evt_word[soc_event_pkg::FC_BIT_GPIO]       = evt_i.gpio_evt;
    // either slow clock edge
    evt_word[soc_event_pkg::FC_BIT_REF_EDGE]   = evt_i.ref_rise | evt_i.ref_fall;
    evt_word[soc_event_pkg::FC_BIT_HWPE0]      = fc_hwpe_events_i[0];
    evt_word[soc_event_pkg::FC_BIT_HWPE1]      = fc_hwpe_events_i[1];
  end

  ////////////////////////////////////////////////////////////////////////////
  // mask and output stage
  ////////////////////////////////////////////////////////////////////////////

  assign cfg_hit = cfg_we_i && (cfg_addr_i == soc_event_pkg::CFG_EVT_MASK);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // everything passes out of reset
      mask_q      <= '1;
      fc_events_o <= '0;
    end else begin
      if (cfg_hit) begin
        mask_q <= cfg_wdata_i.word;
      end
      fc_events_o <= evt_word & mask_q;
    end
  end

  a_reserved_quiet : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (fc_events_o & ~soc_event_pkg::FC_USED_MASK) == '0
  ) else $error("reserved fc event bit set");

endmodule

/* logic/gpio_event_unit.sv */
// gpio edge event unit
`timescale 1ns/1ns

module gpio_event_unit (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  // config strobe
  input  logic                                     cfg_we_i,
  input  logic [soc_event_pkg::CFG_ADDR_WIDTH-1:0] cfg_addr_i,
  input  soc_event_pkg::cfg_word_u                 cfg_wdata_i,
  // async pins
  input  logic [soc_event_pkg::N_GPIO-1:0]         gpio_in_i,
  periph_evt_if.gpio_mp                            evt_o
);

  // two flop synchronizer plus last seen value
  logic [soc_event_pkg::N_GPIO-1:0] sync1_q;
  logic [soc_event_pkg::N_GPIO-1:0] sync2_q;
  logic [soc_event_pkg::N_GPIO-1:0] prev_q;

  // per pin enable and edge select
  soc_event_pkg::gpio_irq_cfg_t irq_cfg_q;

  logic [soc_event_pkg::N_GPIO-1:0] pin_rise;
  logic [soc_event_pkg::N_GPIO-1:0] pin_fall;
  logic [soc_event_pkg::N_GPIO-1:0] pin_fire;
  logic                             cfg_hit;

  ////////////////////////////////////////////////////////////////////////////
  // input sampling
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_in_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  // edges between settled value and previous one
  assign pin_rise = sync2_q & ~prev_q;
  assign pin_fall = ~sync2_q & prev_q;

  // pick the configured edge then gate by enable
  assign pin_fire = irq_cfg_q.irq_en &
                    ((irq_cfg_q.irq_rise & pin_rise) | (~irq_cfg_q.irq_rise & pin_fall));

  ////////////////////////////////////////////////////////////////////////////
  // config and event output
  ////////////////////////////////////////////////////////////////////////////

  assign cfg_hit = cfg_we_i && (cfg_addr_i == soc_event_pkg::CFG_GPIO_IRQ);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      irq_cfg_q      <= '0;
      evt_o.gpio_evt <= 1'b0;
    end else begin
      if (cfg_hit) begin
        irq_cfg_q <= cfg_wdata_i.gpio_irq;
      end
      // one line for all pins
      evt_o.gpio_evt <= |pin_fire;
    end
  end

  // event needs an enabled pin that just changed
  a_no_evt_when_disabled : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    evt_o.gpio_evt |-> $past((irq_cfg_q.irq_en & (sync2_q ^ prev_q)) != '0)
  ) else $error("gpio event raised without an enabled pin edge");

endmodule

/* logic/periph_evt_if.sv */
// peripheral event bundle
`timescale 1ns/1ns

interface periph_evt_if;

  // all single cycle pulses on the system clock
  // slow clock edges
  logic ref_rise;
  logic ref_fall;
  // compare match and counter wrap
  logic timer_lo;
  logic timer_hi;
  // any enabled gpio edge
  logic gpio_evt;

  // timer unit side
  modport timer_mp (
    output ref_rise,
    output ref_fall,
    output timer_lo,
    output timer_hi
  );

  // gpio unit side
  modport gpio_mp (
    output gpio_evt
  );

  // router sees everything
  modport router_mp (
    input ref_rise,
    input ref_fall,
    input timer_lo,
    input timer_hi,
    input gpio_evt
  );

endinterface

/* logic/ref_timer_unit.sv */
// reference clock timer unit
`timescale 1ns/1ns

module ref_timer_unit #(
  parameter int TIMER_WIDTH = 32
) (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  // config strobe
  input  logic                                     cfg_we_i,
  input  logic [soc_event_pkg::CFG_ADDR_WIDTH-1:0] cfg_addr_i,
  input  soc_event_pkg::cfg_word_u                 cfg_wdata_i,
  // slow reference clock, async to clk_i
  input  logic                                     slow_clk_i,
  // freezes the count, edges still pass
  input  logic                                     stoptimer_i,
  periph_evt_if.timer_mp                           evt_o
);

  // slow clock sampling
  logic sync1_q;
  logic sync2_q;
  logic prev_q;
  logic rise_det;
  logic fall_det;

  // counter and compare
  logic [TIMER_WIDTH-1:0] cnt_q;
  logic [TIMER_WIDTH-1:0] cmp_q;
  logic [TIMER_WIDTH-1:0] cnt_inc;
  logic                   cnt_adv;
  logic                   cmp_hit;
  logic                   cnt_wrap;
  logic                   cfg_hit;

  ////////////////////////////////////////////////////////////////////////////
  // edge wedge on the slow clock
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q <= 1'b0;
      sync2_q <= 1'b0;
      prev_q  <= 1'b0;
    end else begin
      sync1_q <= slow_clk_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  assign rise_det = sync2_q & ~prev_q;
  assign fall_det = ~sync2_q & prev_q;

  ////////////////////////////////////////////////////////////////////////////
  // rising edge counter
  ////////////////////////////////////////////////////////////////////////////

  assign cfg_hit = cfg_we_i && (cfg_addr_i == soc_event_pkg::CFG_TIMER_CMP);
  assign cnt_adv = rise_det & ~stoptimer_i;
  assign cnt_inc = cnt_q + TIMER_WIDTH'(1);

  // zero compare turns the match off
  assign cmp_hit = (cmp_q != '0) && (cnt_inc == cmp_q);
  // free running only without a compare value
  assign cnt_wrap = (cmp_q == '0) && (cnt_q == '1);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
      cmp_q <= '0;
    end else if (cfg_hit) begin
      // new compare restarts the count
      cmp_q <= cfg_wdata_i.word[TIMER_WIDTH-1:0];
      cnt_q <= '0;
    end else if (cnt_adv) begin
      cnt_q <= cmp_hit ? '0 : cnt_inc;
    end
  end

  // pulses line up with the ref_rise that caused them
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      evt_o.ref_rise <= 1'b0;
      evt_o.ref_fall <= 1'b0;
      evt_o.timer_lo <= 1'b0;
      evt_o.timer_hi <= 1'b0;
    end else begin
      evt_o.ref_rise <= rise_det;
      evt_o.ref_fall <= fall_det;
      evt_o.timer_lo <= cnt_adv & cmp_hit;
      evt_o.timer_hi <= cnt_adv & cnt_wrap;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // match needs a fresh slow edge every time
  a_lo_single_cycle : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    evt_o.timer_lo |=> !evt_o.timer_lo
  ) else $error("timer low pulse held for two cycles");

  a_rise_fall_exclusive : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(evt_o.ref_rise && evt_o.ref_fall)
  ) else $error("reference rise and fall seen together");

endmodule

/* logic/soc_event_pkg.sv */
// soc event shared definitions

package soc_event_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////////////////////

  // gpio pins watched by the event unit
  parameter int N_GPIO = 16;
  // fabric controller event word
  parameter int FC_EVT_WIDTH = 32;
  // config strobe address
  parameter int CFG_ADDR_WIDTH = 2;

  ////////////////////////////////////////////////////////////////////////////
  // config address map
  ////////////////////////////////////////////////////////////////////////////

  parameter logic [CFG_ADDR_WIDTH-1:0] CFG_TIMER_CMP = 2'd0;
  parameter logic [CFG_ADDR_WIDTH-1:0] CFG_GPIO_IRQ  = 2'd1;
  parameter logic [CFG_ADDR_WIDTH-1:0] CFG_EVT_MASK  = 2'd2;

  ////////////////////////////////////////////////////////////////////////////
  // fc event bit map
  ////////////////////////////////////////////////////////////////////////////

  // timer low shows up twice, bit 7 is the mtime line
  parameter int FC_BIT_TIMER_LO_M = 7;
  parameter int FC_BIT_TIMER_LO   = 16;
  parameter int FC_BIT_TIMER_HI   = 17;
  parameter int FC_BIT_GPIO       = 18;
  // ref clock rise or fall
  parameter int FC_BIT_REF_EDGE   = 23;
  parameter int FC_BIT_HWPE0      = 30;
  parameter int FC_BIT_HWPE1      = 31;

  // everything else in the word is reserved
  parameter logic [FC_EVT_WIDTH-1:0] FC_USED_MASK =
      (FC_EVT_WIDTH'(1) << FC_BIT_TIMER_LO_M) |
      (FC_EVT_WIDTH'(1) << FC_BIT_TIMER_LO)   |
      (FC_EVT_WIDTH'(1) << FC_BIT_TIMER_HI)   |
      (FC_EVT_WIDTH'(1) << FC_BIT_GPIO)       |
      (FC_EVT_WIDTH'(1) << FC_BIT_REF_EDGE)   |
      (FC_EVT_WIDTH'(1) << FC_BIT_HWPE0)      |
      (FC_EVT_WIDTH'(1) << FC_BIT_HWPE1);

  ////////////////////////////////////////////////////////////////////////////
  // config word layouts
  ////////////////////////////////////////////////////////////////////////////

  // gpio irq setting, enables in the upper half
  typedef struct packed {
    logic [N_GPIO-1:0] irq_en;
    // 1 rising, 0 falling
    logic [N_GPIO-1:0] irq_rise;
  } gpio_irq_cfg_t;

  // same 32 bits seen as compare/mask word or gpio setting
  typedef union packed {
    logic [31:0]   word;
    gpio_irq_cfg_t gpio_irq;
  } cfg_word_u;

endpackage

/* logic/soc_event_top.sv */
// soc event top level
`timescale 1ns/1ns

module soc_event_top #(
  parameter int TIMER_WIDTH = 32
) (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  // config strobe, no read back
  input  logic                                     cfg_we_i,
  input  logic [soc_event_pkg::CFG_ADDR_WIDTH-1:0] cfg_addr_i,
  input  logic [31:0]                              cfg_wdata_i,
  // event sources
  input  logic [soc_event_pkg::N_GPIO-1:0]         gpio_in_i,
  input  logic                                     slow_clk_i,
  input  logic                                     stoptimer_i,
  input  logic [1:0]                               fc_hwpe_events_i,
  output logic [soc_event_pkg::FC_EVT_WIDTH-1:0]   fc_events_o
);

  // config word seen through the union by every unit
  soc_event_pkg::cfg_word_u cfg_word;

  assign cfg_word = soc_event_pkg::cfg_word_u'(cfg_wdata_i);

  // pulses from the producers to the router
  periph_evt_if periph_evt ();

  ////////////////////////////////////////////////////////////////////////////
  // producers
  ////////////////////////////////////////////////////////////////////////////

  gpio_event_unit gpio_event_unit_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_word),
    .gpio_in_i   (gpio_in_i),
    .evt_o       (periph_evt.gpio_mp)
  );

  ref_timer_unit #(
    .TIMER_WIDTH (TIMER_WIDTH)
  ) ref_timer_unit_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_word),
    .slow_clk_i  (slow_clk_i),
    .stoptimer_i (stoptimer_i),
    .evt_o       (periph_evt.timer_mp)
  );

  ////////////////////////////////////////////////////////////////////////////
  // router, adds the last register stage
  ////////////////////////////////////////////////////////////////////////////

  fc_event_router fc_event_router_inst (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .cfg_we_i         (cfg_we_i),
    .cfg_addr_i       (cfg_addr_i),
    .cfg_wdata_i      (cfg_word),
    .fc_hwpe_events_i (fc_hwpe_events_i),
    .evt_i            (periph_evt.router_mp),
    .fc_events_o      (fc_events_o)
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the soc event testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f build.f \
  --top-module tb_soc_event_top \
  -Mdir obj_dir \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Everything OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
